//--- logic/synth_pkg.sv
// sample and data widths, midi command and decoder state enums, note half-period table
package synth_pkg;

    // ----------------------------------------------------------------------
    // widths
    // ----------------------------------------------------------------------
    // signed audio sample
    localparam int SMPL_W      = 18;
    // payload bits of a midi data byte
    localparam int MIDI_DATA_W = 7;
    // velocity moves up by this many bits to form the amplitude
    // full velocity gives 130048 so a negated sample still fits
    localparam int AMP_SHIFT   = 10;

    // ----------------------------------------------------------------------
    // enums
    // ----------------------------------------------------------------------
    // low three bits of the status nibble
    // 0x8 and 0x9 land on 0 and 1
    typedef enum logic [2:0] {
        NOTE_OFF = 3'd0,
        NOTE_ON  = 3'd1,
        OTHER    = 3'd7
    } midi_cmd_t;

    // midi parser position within a message
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        DATA0 = 2'd1,
        DATA1 = 2'd2
    } dec_state_t;

    // ----------------------------------------------------------------------
    // note table
    // ----------------------------------------------------------------------
    // half-periods in samples for notes 0 to 11 at a nominal 1 MHz rate
    // higher octaves shift right by note div 12
    localparam logic [15:0] NOTE_HALF_PERIOD [12] = '{
        16'd61156, 16'd57723, 16'd54484, 16'd51426,
        16'd48540, 16'd45815, 16'd43244, 16'd40817,
        16'd38526, 16'd36364, 16'd34323, 16'd32396
    };

endpackage

//--- logic/uart_rx.sv
// 8n1 serial receiver with mid-bit sampling and a one-cycle byte strobe
`timescale 1ns/1ps

module uart_rx #(
    parameter int CLK_FREQ  = 100_000_000,
    parameter int BAUD_RATE = 31_250
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       rx,
    output logic       data_received,
    output logic [7:0] data
);

    // clocks per bit and per half bit
    localparam int BIT_CLKS  = CLK_FREQ / BAUD_RATE;
    localparam int HALF_CLKS = BIT_CLKS / 2;
    localparam int CNT_W     = $clog2(BIT_CLKS + 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t        state;
    // two sync stages plus one more for edge detect
    logic [2:0]       rx_sync;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift;
    logic             rx_s;
    logic             start_edge;
    logic             half_done;
    logic             bit_done;

    assign rx_s       = rx_sync[1];
    assign start_edge = rx_sync[2] & ~rx_sync[1];
    assign half_done  = (cnt == CNT_W'(HALF_CLKS - 1));
    assign bit_done   = (cnt == CNT_W'(BIT_CLKS - 1));

    // ----------------------------------------------------------------------
    // frame FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // idle line is high
            rx_sync       <= '1;
            state         <= RX_IDLE;
            cnt           <= '0;
            bit_idx       <= '0;
            data_received <= 1'b0;
        end else begin
            rx_sync       <= {rx_sync[1:0], rx};
            data_received <= 1'b0;
            cnt           <= cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (start_edge) begin
                        state <= RX_START;
                    end
                end
                // confirm start bit at its middle
                RX_START: begin
                    if (half_done) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_s ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_done) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                // low stop bit means framing error, byte dropped
                RX_STOP: begin
                    if (bit_done) begin
                        cnt           <= '0;
                        data_received <= rx_s;
                        state         <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // lsb first
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_done) begin
            shift <= {rx_s, shift[7:1]};
        end
        if (state == RX_STOP && bit_done) begin
            data <= shift;
        end
    end

    // a frame lasts ten bit times so strobes never touch
    assert property (@(posedge clk) disable iff (!arst_n)
        data_received |=> !data_received);

endmodule

//--- logic/midi_decoder.sv
// midi byte parser with running status producing note on and note off messages
`timescale 1ns/1ps

module midi_decoder #(
    parameter int MIDI_CHANNEL = 0
) (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                data_in_ready,
    input  logic [7:0]                          data_in,
    output logic                                midi_rdy,
    output synth_pkg::midi_cmd_t                midi_cmd,
    output logic [3:0]                          midi_ch_sysn,
    output logic [synth_pkg::MIDI_DATA_W-1:0]   midi_data0,
    output logic [synth_pkg::MIDI_DATA_W-1:0]   midi_data1
);

    localparam int DW = synth_pkg::MIDI_DATA_W;

    synth_pkg::dec_state_t state;
    // running status
    synth_pkg::midi_cmd_t  run_cmd;
    logic [3:0]            run_ch;
    logic [DW-1:0]         data0_q;
    synth_pkg::midi_cmd_t  status_cmd;
    logic                  is_status;
    logic                  is_system;
    logic                  msg_done;
    logic                  msg_ours;

    // command from the incoming status byte
    always_comb begin
        case (data_in[7:4])
            4'h8:    status_cmd = synth_pkg::NOTE_OFF;
            4'h9:    status_cmd = synth_pkg::NOTE_ON;
            default: status_cmd = synth_pkg::OTHER;
        endcase
    end

    assign is_status = data_in_ready & data_in[7];
    assign is_system = is_status & (data_in[7:4] == 4'hF);
    // second data byte closes the message
    assign msg_done  = data_in_ready & ~data_in[7] & (state == synth_pkg::DATA1);
    assign msg_ours  = (run_cmd != synth_pkg::OTHER) && (run_ch == 4'(MIDI_CHANNEL));

    // ----------------------------------------------------------------------
    // parser FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= synth_pkg::IDLE;
            run_cmd  <= synth_pkg::OTHER;
            run_ch   <= '0;
            midi_rdy <= 1'b0;
            midi_cmd <= synth_pkg::OTHER;
        end else begin
            midi_rdy <= 1'b0;
            if (is_system) begin
                state <= synth_pkg::IDLE;
            end else if (is_status) begin
                state   <= synth_pkg::DATA0;
                run_cmd <= status_cmd;
                run_ch  <= data_in[3:0];
            end else if (data_in_ready) begin
                case (state)
                    synth_pkg::DATA0: state <= synth_pkg::DATA1;
                    // back to DATA0 keeps running status
                    synth_pkg::DATA1: state <= synth_pkg::DATA0;
                    default:          state <= synth_pkg::IDLE;
                endcase
            end
            if (msg_done && msg_ours) begin
                midi_rdy <= 1'b1;
                // note on at zero velocity is a note off
                if (run_cmd == synth_pkg::NOTE_ON && data_in[DW-1:0] == '0) begin
                    midi_cmd <= synth_pkg::NOTE_OFF;
                end else begin
                    midi_cmd <= run_cmd;
                end
            end
        end
    end

    // message payload held until the next strobe
    always_ff @(posedge clk) begin
        if (data_in_ready && !data_in[7] && state == synth_pkg::DATA0) begin
            data0_q <= data_in[DW-1:0];
        end
        if (msg_done && msg_ours) begin
            midi_ch_sysn <= run_ch;
            midi_data0   <= data0_q;
            midi_data1   <= data_in[DW-1:0];
        end
    end

    // only note messages leave the decoder
    // and a note on never carries zero velocity
    assert property (@(posedge clk) disable iff (!arst_n)
        midi_rdy |-> midi_cmd != synth_pkg::OTHER &&
                     !(midi_cmd == synth_pkg::NOTE_ON && midi_data1 == '0));

endmodule

//--- logic/pulse_voice.sv
// sample-rate strobe, note state and square-wave stereo sample generator
`timescale 1ns/1ps

module pulse_voice #(
    parameter int SMPL_DIV = 100
) (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               midi_rdy,
    input  synth_pkg::midi_cmd_t               midi_cmd,
    input  logic [synth_pkg::MIDI_DATA_W-1:0]  midi_data0,
    input  logic [synth_pkg::MIDI_DATA_W-1:0]  midi_data1,
    output logic                               note_active,
    output logic                               smpl_out_rdy,
    output logic signed [synth_pkg::SMPL_W-1:0] smpl_out_l,
    output logic signed [synth_pkg::SMPL_W-1:0] smpl_out_r
);

    localparam int SW    = synth_pkg::SMPL_W;
    localparam int DW    = synth_pkg::MIDI_DATA_W;
    localparam int DIV_W = $clog2(SMPL_DIV + 1);

    logic [DIV_W-1:0]     div_cnt;
    logic                 smpl_tick;
    logic [DW-1:0]        note;
    logic signed [SW-1:0] amp;
    logic [15:0]          half_period;
    logic [15:0]          phase_cnt;
    logic                 polarity;
    logic [3:0]           note_idx;
    logic [3:0]           note_oct;
    logic [15:0]          new_half_period;

    // ----------------------------------------------------------------------
    // note state
    // ----------------------------------------------------------------------
    // semitone and octave of the incoming note
    assign note_idx        = 4'(midi_data0 % 7'd12);
    assign note_oct        = 4'(midi_data0 / 7'd12);
    assign new_half_period = synth_pkg::NOTE_HALF_PERIOD[note_idx] >> note_oct;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            note_active <= 1'b0;
        end else if (midi_rdy) begin
            if (midi_cmd == synth_pkg::NOTE_ON) begin
                note_active <= 1'b1;
            end else if (midi_cmd == synth_pkg::NOTE_OFF && midi_data0 == note) begin
                // off for a different note is ignored
                note_active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (midi_rdy && midi_cmd == synth_pkg::NOTE_ON) begin
            note        <= midi_data0;
            amp         <= SW'(midi_data1) << synth_pkg::AMP_SHIFT;
            half_period <= new_half_period;
        end
    end

    // ----------------------------------------------------------------------
    // sample stream
    // ----------------------------------------------------------------------
    assign smpl_tick = (div_cnt == DIV_W'(SMPL_DIV - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt      <= '0;
            smpl_out_rdy <= 1'b0;
            phase_cnt    <= '0;
            polarity     <= 1'b0;
            smpl_out_l   <= '0;
            smpl_out_r   <= '0;
        end else begin
            smpl_out_rdy <= smpl_tick;
            div_cnt      <= smpl_tick ? '0 : div_cnt + 1'b1;
            if (smpl_tick) begin
                if (!note_active) begin
                    // phase restarts with the next note
                    phase_cnt  <= '0;
                    polarity   <= 1'b0;
                    smpl_out_l <= '0;
                    smpl_out_r <= '0;
                end else begin
                    if (phase_cnt >= half_period - 16'd1) begin
                        phase_cnt <= '0;
                        polarity  <= ~polarity;
                    end else begin
                        phase_cnt <= phase_cnt + 16'd1;
                    end
                    // right channel runs inverted
                    smpl_out_l <= polarity ? -amp : amp;
                    smpl_out_r <= polarity ? amp : -amp;
                end
            end
        end
    end

    // a sounding note is never silent and the pair stays mirrored
    assert property (@(posedge clk) disable iff (!arst_n)
        smpl_out_rdy && $past(note_active) |->
            smpl_out_l != '0 && smpl_out_l == -smpl_out_r);

endmodule

//--- logic/stereo_dac_output.sv
// two first-order sigma-delta modulators driving one-bit dac outputs
`timescale 1ns/1ps

module stereo_dac_output (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                sample_in_rdy,
    input  logic signed [synth_pkg::SMPL_W-1:0] sample_in_l,
    input  logic signed [synth_pkg::SMPL_W-1:0] sample_in_r,
    output logic                                dac_out_l,
    output logic                                dac_out_r
);

    localparam int SW = synth_pkg::SMPL_W;

    // index 0 left, 1 right
    logic signed [SW-1:0] smpl_in [2];
    logic [1:0]           dac_bit;

    assign smpl_in[0] = sample_in_l;
    assign smpl_in[1] = sample_in_r;
    assign dac_out_l  = dac_bit[0];
    assign dac_out_r  = dac_bit[1];

    for (genvar ch = 0; ch < 2; ch++) begin : g_ch
        // offset binary level, zero sample sits at mid scale
        logic [SW-1:0] level;
        logic [SW-1:0] acc;
        logic [SW:0]   sum;
        logic          bit_q;

        assign sum         = {1'b0, acc} + {1'b0, level};
        assign dac_bit[ch] = bit_q;

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                level <= SW'(1) << (SW - 1);
                acc   <= '0;
                bit_q <= 1'b0;
            end else begin
                // adding 2^17 is a flip of the sign bit
                if (sample_in_rdy) begin
                    level <= {~smpl_in[ch][SW-1], smpl_in[ch][SW-2:0]};
                end
                // carry out is the pulse density output
                acc   <= sum[SW-1:0];
                bit_q <= sum[SW];
            end
        end
    end

endmodule

//--- logic/synth_top.sv
// top level joining serial receiver, midi decoder, pulse voice and stereo dac
`timescale 1ns/1ps

module synth_top #(
    parameter int CLK_FREQ     = 100_000_000,
    parameter int BAUD_RATE    = 31_250,
    parameter int MIDI_CHANNEL = 0,
    parameter int SMPL_DIV     = 100
) (
    input  logic clk,
    input  logic arst_n,
    input  logic rx,
    output logic dac_out_l,
    output logic dac_out_r,
    // stands in for the board led
    output logic note_active
);

    localparam int SW = synth_pkg::SMPL_W;
    localparam int DW = synth_pkg::MIDI_DATA_W;

    // ----------------------------------------------------------------------
    // serial in to midi messages
    // ----------------------------------------------------------------------
    logic                 data_received;
    logic [7:0]           data;
    logic                 midi_rdy;
    synth_pkg::midi_cmd_t midi_cmd;
    logic [DW-1:0]        midi_data0;
    logic [DW-1:0]        midi_data1;

    uart_rx #(
        .CLK_FREQ (CLK_FREQ),
        .BAUD_RATE(BAUD_RATE)
    ) uart_rx (
        .clk          (clk          ),
        .arst_n       (arst_n       ),
        .rx           (rx           ),
        .data_received(data_received),
        .data         (data         )
    );

    // channel filtering happens inside, channel out left open
    midi_decoder #(
        .MIDI_CHANNEL(MIDI_CHANNEL)
    ) midi_decoder (
        .clk          (clk          ),
        .arst_n       (arst_n       ),
        .data_in_ready(data_received),
        .data_in      (data         ),
        .midi_rdy     (midi_rdy     ),
        .midi_cmd     (midi_cmd     ),
        .midi_ch_sysn (             ),
        .midi_data0   (midi_data0   ),
        .midi_data1   (midi_data1   )
    );

    // ----------------------------------------------------------------------
    // voice and dac
    // ----------------------------------------------------------------------
    logic                 smpl_out_rdy;
    logic signed [SW-1:0] smpl_out_l;
    logic signed [SW-1:0] smpl_out_r;

    pulse_voice #(
        .SMPL_DIV(SMPL_DIV)
    ) pulse_voice (
        .clk         (clk         ),
        .arst_n      (arst_n      ),
        .midi_rdy    (midi_rdy    ),
        .midi_cmd    (midi_cmd    ),
        .midi_data0  (midi_data0  ),
        .midi_data1  (midi_data1  ),
        .note_active (note_active ),
        .smpl_out_rdy(smpl_out_rdy),
        .smpl_out_l  (smpl_out_l  ),
        .smpl_out_r  (smpl_out_r  )
    );

    stereo_dac_output stereo_dac_output (
        .clk          (clk         ),
        .arst_n       (arst_n      ),
        .sample_in_rdy(smpl_out_rdy),
        .sample_in_l  (smpl_out_l  ),
        .sample_in_r  (smpl_out_r  ),
        .dac_out_l    (dac_out_l   ),
        .dac_out_r    (dac_out_r   )
    );

endmodule

//--- bench/synth_checker.sv
// serial byte decoder, note state model, dac window counts and the comparisons
`timescale 1ns/1ps

module synth_checker #(
    parameter int MIDI_CHANNEL = 3,
    parameter int SMPL_DIV     = 4
) (
    input  logic clk,
    input  logic arst_n,
    input  logic rx,
    input  logic note_active,
    input  logic dac_out_l,
    input  logic dac_out_r,
    output int   value_errors,
    output int   tones_judged
);

    localparam int BIT_CLKS = 10;
    // window fill plus the sample strobe delay, with margin
    localparam int SETTLE   = 512;

    // serial side
    logic         busy;
    int           bit_cnt;
    logic [9:0]   frame;
    // midi parse, status 0 means no running status
    logic [7:0]   status;
    int           data_idx;
    logic [6:0]   d0;
    // expected note state
    logic         exp_active;
    logic [6:0]   exp_note;
    int           exp_vel;
    int           stable_cnt;
    logic         led_bad;
    // one-counts over the last 256 clocks, index 0 left, 1 right
    logic [1:0]   dac_bits;
    logic [255:0] hist [2];
    int           win [2];
    int           win_max [2];
    int           win_min [2];
    int           quiet_cnt;
    logic         quiet_bad;
    int           tone_cnt;
    int           tone_len;
    int           hp;
    logic         bad;

    assign dac_bits = {dac_out_r, dac_out_l};

    // ----------------------------------------------------------------------
    // note model
    // ----------------------------------------------------------------------
    task automatic apply_msg(input logic [6:0] d1);
        logic on;
        logic off;
        on  = (status[7:4] == 4'h9) && (d1 != 7'd0);
        off = (status[7:4] == 4'h8) || ((status[7:4] == 4'h9) && (d1 == 7'd0));
        if (status[3:0] == 4'(MIDI_CHANNEL) && (on || off)) begin
            if (on) begin
                exp_active = 1'b1;
                exp_note   = d0;
                exp_vel    = d1;
            end else if (d0 == exp_note) begin
                exp_active = 1'b0;
            end
            // measurements restart on any message for our channel
            stable_cnt = 0;
            tone_cnt   = 0;
        end
    endtask

    task automatic apply_byte(input logic [7:0] b);
        if (b[7]) begin
            // system bytes drop running status
            status   = (b >= 8'hF0) ? 8'h00 : b;
            data_idx = 0;
        end else if (status != 8'h00) begin
            if (data_idx == 0) begin
                d0       = b[6:0];
                data_idx = 1;
            end else begin
                data_idx = 0;
                apply_msg(b[6:0]);
            end
        end
    endtask

    task automatic check_count(input string sig, input int exp, input int act, input int tol,
                               output logic fail);
        fail = (act < exp - tol) || (act > exp + tol);
        if (fail) begin
            $display("FAILED %s: expected %h actual %h", sig, exp, act);
            value_errors++;
        end
    endtask

    // ----------------------------------------------------------------------
    // per-clock watch
    // ----------------------------------------------------------------------
    always @(posedge clk) begin
        if (!arst_n) begin
            busy       = 1'b0;
            status     = 8'h00;
            data_idx   = 0;
            exp_active = 1'b0;
            exp_note   = '0;
            exp_vel    = 0;
            stable_cnt = 0;
            led_bad    = 1'b0;
            hist       = '{default: '0};
            win        = '{default: 0};
            quiet_cnt  = 0;
            quiet_bad  = 1'b0;
            tone_cnt   = 0;
            tone_len   = 0;
        end else begin
            // mid-bit sampling, start bit seen at count 0
            if (!busy) begin
                if (!rx) begin
                    busy    = 1'b1;
                    bit_cnt = 0;
                end
            end else begin
                bit_cnt++;
                if (bit_cnt % BIT_CLKS == BIT_CLKS / 2) begin
                    frame[bit_cnt / BIT_CLKS] = rx;
                end
                if (bit_cnt == 9 * BIT_CLKS + BIT_CLKS / 2) begin
                    busy = 1'b0;
                    if (frame[9] && !frame[0]) begin
                        apply_byte(frame[8:1]);
                    end
                end
            end

            // led compare once the dut had time to follow
            stable_cnt++;
            if (stable_cnt > 16 && note_active !== exp_active) begin
                if (!led_bad) begin
                    $display("FAILED note_active: expected %h actual %h", exp_active, note_active);
                    value_errors++;
                end
                led_bad = 1'b1;
            end else begin
                led_bad = 1'b0;
            end

            for (int ch = 0; ch < 2; ch++) begin
                win[ch]  = win[ch] + dac_bits[ch] - hist[ch][255];
                hist[ch] = {hist[ch][254:0], dac_bits[ch]};
            end

            // silence sits at mid scale
            if (!exp_active && !note_active) begin
                quiet_cnt++;
            end else begin
                quiet_cnt = 0;
                quiet_bad = 1'b0;
            end
            if (quiet_cnt > SETTLE && !quiet_bad) begin
                check_count("dac_out_l silence count", 128, win[0], 2, bad);
                quiet_bad = bad;
                check_count("dac_out_r silence count", 128, win[1], 2, bad);
                quiet_bad = quiet_bad | bad;
            end

            // tone range over two half-periods
            if (exp_active && note_active) begin
                tone_cnt++;
            end else begin
                tone_cnt = 0;
            end
            if (tone_cnt == SETTLE) begin
                hp       = synth_pkg::NOTE_HALF_PERIOD[exp_note % 12] >> (exp_note / 12);
                tone_len = SETTLE + 2 * hp * SMPL_DIV;
                win_max  = win;
                win_min  = win;
            end else if (tone_cnt > SETTLE) begin
                for (int ch = 0; ch < 2; ch++) begin
                    win_max[ch] = (win[ch] > win_max[ch]) ? win[ch] : win_max[ch];
                    win_min[ch] = (win[ch] < win_min[ch]) ? win[ch] : win_min[ch];
                end
                if (tone_cnt == tone_len) begin
                    check_count("dac_out_l window max", 128 + exp_vel, win_max[0], 3, bad);
                    check_count("dac_out_l window min", 128 - exp_vel, win_min[0], 3, bad);
                    check_count("dac_out_r window max", 128 + exp_vel, win_max[1], 3, bad);
                    check_count("dac_out_r window min", 128 - exp_vel, win_min[1], 3, bad);
                    tones_judged <= tones_judged + 1;
                end
            end
        end
    end

endmodule

//--- bench/tb_synth.sv
// testbench top with clock, reset, serial midi stimulus, the dut and the checker
`timescale 1ns/1ps

module tb_synth;

    localparam int CLK_FREQ     = 100_000_000;
    localparam int BAUD_RATE    = 10_000_000;
    localparam int MIDI_CHANNEL = 3;
    localparam int SMPL_DIV     = 4;

    logic       clk;
    logic       arst_n;
    logic       rx;
    logic       dac_out_l;
    logic       dac_out_r;
    logic       note_active;
    int         value_errors;
    int         tones_judged;
    int         timeouts;
    int         seed;
    logic [7:0] last_status;
    logic [6:0] last_note;

    synth_top #(
        .CLK_FREQ    (CLK_FREQ    ),
        .BAUD_RATE   (BAUD_RATE   ),
        .MIDI_CHANNEL(MIDI_CHANNEL),
        .SMPL_DIV    (SMPL_DIV    )
    ) i_synth_top (
        .clk        (clk        ),
        .arst_n     (arst_n     ),
        .rx         (rx         ),
        .dac_out_l  (dac_out_l  ),
        .dac_out_r  (dac_out_r  ),
        .note_active(note_active)
    );

    synth_checker #(
        .MIDI_CHANNEL(MIDI_CHANNEL),
        .SMPL_DIV    (SMPL_DIV    )
    ) i_checker (
        .clk         (clk         ),
        .arst_n      (arst_n      ),
        .rx          (rx          ),
        .note_active (note_active ),
        .dac_out_l   (dac_out_l   ),
        .dac_out_r   (dac_out_r   ),
        .value_errors(value_errors),
        .tones_judged(tones_judged)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    // ----------------------------------------------------------------------
    // serial drive
    // ----------------------------------------------------------------------
    // 8n1, lsb first, ten clocks per bit
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #1;
            rx = frame[i];
            repeat (9) @(posedge clk);
        end
    endtask

    // status byte skipped when running status applies
    task automatic send_msg(input logic [7:0] status, input logic [6:0] d0,
                            input logic [6:0] d1, input logic running);
        if (!running || status != last_status) begin
            send_byte(status);
        end
        send_byte({1'b0, d0});
        send_byte({1'b0, d1});
        last_status = status;
    endtask

    task automatic idle(input int clocks);
        repeat (clocks) @(posedge clk);
    endtask

    task automatic wait_led(input logic level);
        int n;
        n = 0;
        while (note_active !== level && n < 2000) begin
            @(posedge clk);
            n++;
        end
        if (note_active !== level) begin
            $display("timeout waiting for note_active to become %0d", level);
            timeouts++;
        end
    endtask

    task automatic wait_tone();
        int start;
        int n;
        start = tones_judged;
        n     = 0;
        while (tones_judged == start && n < 80000) begin
            @(posedge clk);
            n++;
        end
        if (tones_judged == start) begin
            $display("timeout waiting for the tone amplitude measurement");
            timeouts++;
        end
    endtask

    // ----------------------------------------------------------------------
    // test sequences
    // ----------------------------------------------------------------------
    task automatic tone_test();
        logic [6:0] n;
        logic [6:0] v;
        n = 7'(rand_range(36, 84));
        v = 7'(rand_range(1, 127));
        send_msg(8'h93, n, v, 1'b0);
        wait_led(1'b1);
        wait_tone();
        // off for another note keeps it sounding
        send_msg(8'h83, n + 7'd1, 7'h40, 1'b0);
        idle(200);
        send_msg(8'h83, n, 7'h40, 1'b0);
        wait_led(1'b0);
    endtask

    task automatic random_msg();
        logic [3:0] ch;
        logic [7:0] status;
        logic [6:0] n;
        logic [6:0] v;
        ch     = (rand_range(0, 1) == 0) ? 4'd3 : 4'(rand_range(0, 15));
        status = {(rand_range(0, 1) == 1) ? 4'h9 : 4'h8, ch};
        n      = (rand_range(0, 1) == 0) ? last_note : 7'(rand_range(36, 84));
        v      = (rand_range(0, 7) == 0) ? 7'd0 : 7'(rand_range(1, 127));
        send_msg(status, n, v, rand_range(0, 1) == 1);
        if (status[7:4] == 4'h9 && v != 7'd0) begin
            last_note = n;
        end
        idle(rand_range(20, 200));
    endtask

    initial begin
        seed        = 72;
        timeouts    = 0;
        last_status = 8'h00;
        last_note   = 7'd60;
        rx          = 1'b1;
        arst_n      = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        idle(800);

        repeat (3) tone_test();

        // velocity zero ends the note
        send_msg(8'h93, 7'd60, 7'd100, 1'b0);
        wait_led(1'b1);
        send_msg(8'h93, 7'd60, 7'd0, 1'b0);
        wait_led(1'b0);

        // other channels never reach the voice
        for (int i = 0; i < 4; i++) begin
            send_msg({4'h9, 4'((3 + rand_range(1, 15)) % 16)}, 7'(rand_range(36, 84)),
                     7'(rand_range(1, 127)), 1'b0);
            idle(200);
        end

        // later pairs ride on the first status byte
        send_msg(8'h93, 7'd48, 7'd90, 1'b0);
        wait_led(1'b1);
        send_msg(8'h93, 7'd52, 7'd70, 1'b1);
        send_msg(8'h93, 7'd48, 7'd0, 1'b1);
        idle(200);
        send_msg(8'h93, 7'd52, 7'd0, 1'b1);
        wait_led(1'b0);

        for (int i = 0; i < 40; i++) begin
            random_msg();
        end
        idle(1000);

        $display("value errors %0d, timeouts %0d", value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- sim.f
logic/synth_pkg.sv
logic/uart_rx.sv
logic/midi_decoder.sv
logic/pulse_voice.sv
logic/stereo_dac_output.sv
logic/synth_top.sv
bench/synth_checker.sv
bench/tb_synth.sv
